//--- src/trg_defs.svh
`ifndef TRG_DEFS_SVH
`define TRG_DEFS_SVH

// stream beat as delivered by the converter
`define TRG_TDATA_WIDTH 128

// one sample slot inside a beat
`define TRG_SLOT_WIDTH 16

// slots per beat
`define TRG_SAMPLES 8

// converter resolution, sample sits in the upper bits of its slot
`define TRG_ADC_WIDTH 12

// free-running time stamp
`define TRG_TS_WIDTH 44

// valid beats kept open after the last hit beat
`define TRG_POST_LEN 38

// longest window in beats
`define TRG_ACQUI_LEN 100

`endif

//--- src/trg_pkg.sv
`include "trg_defs.svh"

package trg_pkg;

  // raw converter sample
  typedef logic signed [`TRG_ADC_WIDTH-1:0] adc_sample_t;

  // one bit wider than a sample, so that sample minus baseline cannot wrap
  typedef logic signed [`TRG_ADC_WIDTH:0] threshold_t;

  // registered beat as it moves down the pipeline
  typedef struct packed {
    // samples right-aligned and zero-padded per slot
    logic [`TRG_TDATA_WIDTH-1:0] data;
    logic                        valid;
    // at least one sample crossed the threshold
    logic                        hit;
    // time of the edge that took the beat in
    logic [`TRG_TS_WIDTH-1:0]    time_stamp;
  } beat_t;

  // record of one window start
  typedef struct packed {
    logic [`TRG_TS_WIDTH-1:0] time_stamp;
    adc_sample_t              baseline;
    threshold_t               threshold;
  } hit_info_t;

endpackage

//--- src/time_base.sv
`include "trg_defs.svh"

module time_base (
  input  logic                     CLK,
  input  logic                     hit_flag_negedge,
  output logic [`TRG_TS_WIDTH-1:0] now
);

  // free-running tick count since reset release
  logic [`TRG_TS_WIDTH-1:0] count;

  always_ff @(posedge CLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      count <= '0;
    end else begin
      // wraps after 2**44 cycles, far beyond any run
      count <= count + 1'b1;
    end
  end

  assign now = count;

endmodule

//--- src/sample_threshold.sv
`include "trg_defs.svh"

module sample_threshold (
  input  logic                        CLK,
  input  logic                        hit_flag_negedge,
  input  logic [`TRG_TDATA_WIDTH-1:0] tdata,
  input  logic                        tvalid,
  input  trg_pkg::threshold_t         threshold,
  input  trg_pkg::adc_sample_t        baseline,
  input  logic [`TRG_TS_WIDTH-1:0]    now,
  output trg_pkg::beat_t              stage1,
  output trg_pkg::threshold_t         threshold_q,
  output trg_pkg::adc_sample_t        baseline_q
);

  import trg_pkg::*;

  // zero bits below the sample in each slot
  localparam int PAD_W = `TRG_SLOT_WIDTH - `TRG_ADC_WIDTH;

  adc_sample_t                 sample [`TRG_SAMPLES];
  threshold_t                  diff [`TRG_SAMPLES];
  logic [`TRG_SAMPLES-1:0]     over_thr;
  logic [`TRG_TDATA_WIDTH-1:0] data_d;
  logic                        hit_d;

  logic [`TRG_TDATA_WIDTH-1:0] data_q;
  logic [`TRG_TS_WIDTH-1:0]    ts_q;
  logic                        valid_q;
  logic                        hit_q;

  // per slot: unpack, subtract baseline, compare, repack right-aligned
  always_comb begin
    for (int i = 0; i < `TRG_SAMPLES; i++) begin
      sample[i] = tdata[`TRG_SLOT_WIDTH*i + PAD_W +: `TRG_ADC_WIDTH];
      // both sides sign-extended to 13 bits before the subtraction
      diff[i] = threshold_t'(sample[i]) - threshold_t'(baseline);
      over_thr[i] = (diff[i] >= threshold);
      data_d[`TRG_SLOT_WIDTH*i +: `TRG_SLOT_WIDTH] = {{PAD_W{1'b0}}, sample[i]};
    end
  end

  // any slot at or above threshold, valid beats only
  assign hit_d = tvalid & (|over_thr);

  always_ff @(posedge CLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      valid_q <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      valid_q <= tvalid;
      hit_q   <= hit_d;
    end
  end

  always_ff @(posedge CLK) begin
    // idle beats carry all ones as on the converter side
    data_q      <= tvalid ? data_d : '1;
    ts_q        <= now;
    // settings that judged this beat, for the window record
    threshold_q <= threshold;
    baseline_q  <= baseline;
  end

  assign stage1 = '{data: data_q, valid: valid_q, hit: hit_q, time_stamp: ts_q};

endmodule

//--- src/hit_window_ctrl.sv
`include "trg_defs.svh"

module hit_window_ctrl (
  input  logic           CLK,
  input  logic           hit_flag_negedge,
  input  trg_pkg::beat_t stage1,
  output logic           hit_rise,
  output trg_pkg::beat_t beat_out,
  output logic           triggered
);

  localparam int POST_CW = $clog2(`TRG_POST_LEN + 1);
  localparam int LEN_CW  = $clog2(`TRG_ACQUI_LEN + 1);

  // hit of the last valid beat, gaps leave it alone
  logic               prev_hit;
  logic               hit_fall;

  // post-hit part of the window
  logic [POST_CW-1:0] post_cnt;
  logic [POST_CW-1:0] post_base;
  logic [POST_CW-1:0] post_next;
  logic               finalize;
  logic               in_post;

  // beats marked since the window opened
  logic [LEN_CW-1:0]  len_cnt;
  logic [LEN_CW-1:0]  len_base;
  logic [LEN_CW-1:0]  len_next;
  logic               over_len;
  logic               over_len_eff;

  logic               window_open;
  logic               trig_d;

  // outgoing beat
  logic [`TRG_TDATA_WIDTH-1:0] data_q;
  logic [`TRG_TS_WIDTH-1:0]    ts_q;
  logic                        valid_q;
  logic                        hit_q;
  logic                        trig_q;

  // edges are judged between valid beats only
  assign hit_rise = stage1.valid & stage1.hit & ~prev_hit;
  assign hit_fall = stage1.valid & ~stage1.hit & prev_hit;

  // first quiet beat after a hit run counts as post beat number one
  assign in_post     = hit_fall | (stage1.valid & ~stage1.hit & finalize);
  assign window_open = (stage1.valid & stage1.hit) | in_post;

  // a rising edge lifts the cap for its own beat
  assign over_len_eff = over_len & ~hit_rise;
  assign trig_d       = window_open & ~over_len_eff;

  assign post_base = hit_fall ? '0 : post_cnt;
  assign post_next = post_base + 1'b1;
  assign len_base  = hit_rise ? '0 : len_cnt;
  assign len_next  = len_base + 1'b1;

  always_ff @(posedge CLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      prev_hit <= 1'b0;
      post_cnt <= '0;
      finalize <= 1'b0;
      len_cnt  <= '0;
      over_len <= 1'b0;
    end else if (stage1.valid) begin
      prev_hit <= stage1.hit;

      if (stage1.hit) begin
        finalize <= 1'b0;
      end else if (in_post) begin
        post_cnt <= post_next;
        // stays set until the last post beat has gone by
        finalize <= (post_next < POST_CW'(`TRG_POST_LEN));
      end

      // cap check on every marked beat, cleared again by a rise
      if (trig_d) begin
        len_cnt  <= len_next;
        over_len <= (len_next == LEN_CW'(`TRG_ACQUI_LEN));
      end
    end
  end

  always_ff @(posedge CLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      valid_q <= 1'b0;
      hit_q   <= 1'b0;
      trig_q  <= 1'b0;
    end else begin
      valid_q <= stage1.valid;
      hit_q   <= stage1.hit;
      trig_q  <= trig_d;
    end
  end

  always_ff @(posedge CLK) begin
    data_q <= stage1.data;
    ts_q   <= stage1.time_stamp;
  end

  // triggered lines up with the beat it marks
  assign beat_out  = '{data: data_q, valid: valid_q, hit: hit_q, time_stamp: ts_q};
  assign triggered = trig_q;

endmodule

//--- src/hit_info_latch.sv
module hit_info_latch (
  input  logic                 CLK,
  input  logic                 hit_flag_negedge,
  input  logic                 hit_rise,
  input  trg_pkg::beat_t       stage1,
  input  trg_pkg::threshold_t  threshold_q,
  input  trg_pkg::adc_sample_t baseline_q,
  output trg_pkg::hit_info_t   hit_info
);

  // record of the current window, loaded with the crossing beat
  always_ff @(posedge CLK or posedge hit_flag_negedge) begin
    if (hit_flag_negedge) begin
      hit_info <= '0;
    end else if (hit_rise) begin
      // time, baseline and threshold all belong to the same beat
      hit_info <= '{
        time_stamp: stage1.time_stamp,
        baseline:   baseline_q,
        threshold:  threshold_q
      };
    end
  end

endmodule

//--- src/mm_trigger_top.sv
`include "trg_defs.svh"

module mm_trigger_top (
  input  logic                        CLK,
  input  logic                        hit_flag_negedge,
  input  logic [`TRG_TDATA_WIDTH-1:0] tdata,
  input  logic                        tvalid,
  input  trg_pkg::threshold_t         threshold,
  input  trg_pkg::adc_sample_t        baseline,
  output trg_pkg::beat_t              beat_out,
  output logic                        triggered,
  output trg_pkg::hit_info_t          hit_info
);

  import trg_pkg::*;

  logic [`TRG_TS_WIDTH-1:0] now;
  beat_t                    stage1;
  threshold_t               threshold_q;
  adc_sample_t              baseline_q;
  logic                     hit_rise;

  time_base u_time_base (
    .CLK              (CLK),
    .hit_flag_negedge (hit_flag_negedge),
    .now              (now)
  );

  // first stage, compare and register
  sample_threshold u_sample_threshold (
    .CLK              (CLK),
    .hit_flag_negedge (hit_flag_negedge),
    .tdata            (tdata),
    .tvalid           (tvalid),
    .threshold        (threshold),
    .baseline         (baseline),
    .now              (now),
    .stage1           (stage1),
    .threshold_q      (threshold_q),
    .baseline_q       (baseline_q)
  );

  // second stage, window decision
  hit_window_ctrl u_hit_window_ctrl (
    .CLK              (CLK),
    .hit_flag_negedge (hit_flag_negedge),
    .stage1           (stage1),
    .hit_rise         (hit_rise),
    .beat_out         (beat_out),
    .triggered        (triggered)
  );

  hit_info_latch u_hit_info_latch (
    .CLK              (CLK),
    .hit_flag_negedge (hit_flag_negedge),
    .hit_rise         (hit_rise),
    .stage1           (stage1),
    .threshold_q      (threshold_q),
    .baseline_q       (baseline_q),
    .hit_info         (hit_info)
  );

endmodule

//--- tests/tb_mm_trigger_tasks.svh
`ifndef TB_MM_TRIGGER_TASKS_SVH
`define TB_MM_TRIGGER_TASKS_SVH

task automatic report_failure(input string what);
  $display("[FAIL] %0t ns: %s", $time, what);
  $display("Simulation finished: FAIL");
  $fatal(1);
endtask

task automatic check_val(input string name, input logic [255:0] got,
                         input logic [255:0] exp);
  if (got !== exp) begin
    $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end
endtask

function automatic void clear_model();
  m_prev      = 1'b0;
  m_post_left = 0;
  m_len       = 0;
  m_capped    = 1'b0;
  m_rec       = '0;
  m_edges     = '0;
endfunction

// sample sits in the upper 12 bits of each 16-bit slot
function automatic logic [`TRG_TDATA_WIDTH-1:0] beat_with(input int fill, input int slot,
                                                         input int val);
  logic [`TRG_TDATA_WIDTH-1:0] d;
  logic [11:0]                 s;
  for (int i = 0; i < `TRG_SAMPLES; i++) begin
    s = (i == slot) ? val[11:0] : fill[11:0];
    d[16*i +: 16] = {s, 4'b0000};
  end
  return d;
endfunction

// every slot somewhat below baseline plus threshold
function automatic logic [`TRG_TDATA_WIDTH-1:0] noise_beat();
  logic [`TRG_TDATA_WIDTH-1:0] d;
  int                          v;
  for (int i = 0; i < `TRG_SAMPLES; i++) begin
    v = int'(m_bl) + int'(m_thr) - 1 - int'($unsigned($random(seed)) % 64);
    if (v < -2048) v = -2048;
    if (v > 2047) v = 2047;
    d[16*i +: 16] = {v[11:0], 4'b0000};
  end
  return d;
endfunction

function automatic logic beat_hits(input logic [`TRG_TDATA_WIDTH-1:0] d);
  int s;
  for (int i = 0; i < `TRG_SAMPLES; i++) begin
    s = $signed(d[16*i+4 +: 12]);
    if (s - int'(m_bl) >= int'(m_thr)) return 1'b1;
  end
  return 1'b0;
endfunction

function automatic logic [`TRG_TDATA_WIDTH-1:0] right_align(
    input logic [`TRG_TDATA_WIDTH-1:0] d);
  logic [`TRG_TDATA_WIDTH-1:0] r;
  for (int i = 0; i < `TRG_SAMPLES; i++) begin
    r[16*i +: 16] = {4'b0000, d[16*i+4 +: 12]};
  end
  return r;
endfunction

// one beat per clock, model result queued for two cycles later
task automatic drive_beat(input logic [`TRG_TDATA_WIDTH-1:0] d, input logic v);
  expect_t e;
  logic    h;
  logic    trig;
  @(posedge CLK);
  tdata     <= d;
  tvalid    <= v;
  threshold <= m_thr;
  baseline  <= m_bl;
  m_edges = m_edges + 1'b1;
  h = v && beat_hits(d);
  trig = 1'b0;
  if (v) begin
    if (h) begin
      if (!m_prev) begin
        // window start
        m_len = 0;
        m_capped = 1'b0;
        m_rec.time_stamp = m_edges;
        m_rec.baseline = m_bl;
        m_rec.threshold = m_thr;
      end
      m_post_left = `TRG_POST_LEN;
      trig = !m_capped;
    end else if (m_post_left > 0) begin
      m_post_left = m_post_left - 1;
      trig = !m_capped;
    end
    if (trig) begin
      m_len = m_len + 1;
      if (m_len == `TRG_ACQUI_LEN) m_capped = 1'b1;
    end
    m_prev = h;
  end
  e.due = neg_cnt + 3;
  e.beat.data = v ? right_align(d) : '1;
  e.beat.valid = v;
  e.beat.hit = h;
  e.beat.time_stamp = m_edges;
  e.trig = trig;
  e.info = m_rec;
  exp_q.push_back(e);
endtask

// outputs must be cleared as soon as reset is seen
task automatic apply_reset();
  @(posedge CLK);
  hit_flag_negedge <= 1'b1;
  tvalid           <= 1'b0;
  exp_q.delete();
  @(negedge CLK);
  check_val("triggered", triggered, 1'b0);
  check_val("beat_out.valid", beat_out.valid, 1'b0);
  check_val("beat_out.hit", beat_out.hit, 1'b0);
  check_val("hit_info", hit_info, '0);
  repeat (5) @(posedge CLK);
  hit_flag_negedge <= 1'b0;
  clear_model();
endtask

task automatic wait_window_closed();
  int n;
  for (n = 0; n < 300 && m_post_left > 0; n++) begin
    drive_beat(noise_beat(), 1'b1);
  end
  if (m_post_left > 0) report_failure("window did not close within 300 beats");
  // let the last beats reach the output
  repeat (3) drive_beat(noise_beat(), 1'b1);
endtask

task automatic pass_through();
  int start;
  start = trig_count;
  m_bl  = 12'sd0;
  m_thr = 13'sd200;
  for (int i = 0; i < 24; i++) begin
    drive_beat(noise_beat(), (i % 5) != 3);
  end
  wait_window_closed();
  check_val("trig_count", trig_count, start);
endtask

task automatic threshold_crossing();
  int bl [4] = '{300, -500, 100, -1000};
  int th [4] = '{50, 120, -20, -300};
  int start;
  for (int k = 0; k < 4; k++) begin
    start = trig_count;
    m_bl  = bl[k][11:0];
    m_thr = th[k][12:0];
    repeat (4) drive_beat(noise_beat(), 1'b1);
    // one below the limit, then exactly on it
    drive_beat(beat_with(bl[k] + th[k] - 1, 3, bl[k] + th[k] - 1), 1'b1);
    drive_beat(beat_with(bl[k] + th[k] - 1, 5, bl[k] + th[k]), 1'b1);
    wait_window_closed();
    check_val("trig_count", trig_count - start, 1 + `TRG_POST_LEN);
  end
endtask

task automatic post_window();
  int start;
  start = trig_count;
  m_bl  = 12'sd0;
  m_thr = 13'sd400;
  for (int i = 0; i < 5; i++) begin
    drive_beat(beat_with(0, 0, 400 + i), 1'b1);
  end
  // idle gaps inside the post window
  for (int i = 0; i < 60; i++) begin
    drive_beat(noise_beat(), (i % 7) != 2);
  end
  wait_window_closed();
  check_val("trig_count", trig_count - start, 5 + `TRG_POST_LEN);
endtask

task automatic length_cap();
  int start;
  start = trig_count;
  m_bl  = -12'sd100;
  m_thr = 13'sd300;
  for (int i = 0; i < `TRG_ACQUI_LEN + 30; i++) begin
    drive_beat(beat_with(0, i % 8, 250), 1'b1);
  end
  drive_beat(noise_beat(), 1'b1);
  for (int i = 0; i < 5; i++) begin
    drive_beat(beat_with(0, 7, 300), 1'b1);
  end
  wait_window_closed();
  check_val("trig_count", trig_count - start, `TRG_ACQUI_LEN + 5 + `TRG_POST_LEN);
endtask

task automatic hit_record();
  m_bl  = 12'sd50;
  m_thr = 13'sd100;
  repeat (2) drive_beat(noise_beat(), 1'b1);
  drive_beat(beat_with(0, 2, 150), 1'b1);
  // new settings while hits go on must not touch the record
  m_bl  = 12'sd60;
  m_thr = 13'sd90;
  for (int i = 0; i < 6; i++) begin
    drive_beat(beat_with(0, i, 200), 1'b1);
  end
  repeat (10) drive_beat(noise_beat(), 1'b1);
  wait_window_closed();
  m_bl  = -12'sd700;
  m_thr = -13'sd40;
  repeat (3) drive_beat(noise_beat(), 1'b1);
  drive_beat(beat_with(-900, 4, -740), 1'b1);
  wait_window_closed();
endtask

task automatic reset_mid_window();
  m_bl  = 12'sd20;
  m_thr = 13'sd80;
  for (int i = 0; i < 10; i++) begin
    drive_beat(beat_with(0, 1, 100 + i), 1'b1);
  end
  apply_reset();
  repeat (4) drive_beat(noise_beat(), 1'b1);
  drive_beat(beat_with(0, 6, 100), 1'b1);
  wait_window_closed();
endtask

`endif

//--- tests/tb_mm_trigger.sv
`include "trg_defs.svh"

module tb_mm_trigger;

  timeunit 1ns;
  timeprecision 1ps;

  import trg_pkg::*;

  // one expected output beat, due at a given falling edge
  typedef struct packed {
    logic [31:0] due;
    beat_t       beat;
    logic        trig;
    hit_info_t   info;
  } expect_t;

  logic                        CLK;
  logic                        hit_flag_negedge;
  logic [`TRG_TDATA_WIDTH-1:0] tdata;
  logic                        tvalid;
  threshold_t                  threshold;
  adc_sample_t                 baseline;
  beat_t                       beat_out;
  logic                        triggered;
  hit_info_t                   hit_info;

  integer  seed;
  int      neg_cnt;
  int      trig_count;
  expect_t exp_q[$];
  expect_t cur_exp;

  // reference model state
  adc_sample_t              m_bl;
  threshold_t               m_thr;
  logic                     m_prev;
  int                       m_post_left;
  int                       m_len;
  logic                     m_capped;
  hit_info_t                m_rec;
  logic [`TRG_TS_WIDTH-1:0] m_edges;

  mm_trigger_top dut0 (
    .CLK              (CLK),
    .hit_flag_negedge (hit_flag_negedge),
    .tdata            (tdata),
    .tvalid           (tvalid),
    .threshold        (threshold),
    .baseline         (baseline),
    .beat_out         (beat_out),
    .triggered        (triggered),
    .hit_info         (hit_info)
  );

  `include "tb_mm_trigger_tasks.svh"

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // outputs are compared in the middle of the cycle
  always @(negedge CLK) begin
    neg_cnt = neg_cnt + 1;
    if (exp_q.size() > 0) begin
      if (exp_q[0].due < neg_cnt) begin
        report_failure("an expected beat never reached the output");
      end else if (exp_q[0].due == neg_cnt) begin
        cur_exp = exp_q.pop_front();
        check_val("beat_out.data", beat_out.data, cur_exp.beat.data);
        check_val("beat_out.valid", beat_out.valid, cur_exp.beat.valid);
        check_val("beat_out.hit", beat_out.hit, cur_exp.beat.hit);
        check_val("beat_out.time_stamp", beat_out.time_stamp, cur_exp.beat.time_stamp);
        check_val("triggered", triggered, cur_exp.trig);
        check_val("hit_info", hit_info, cur_exp.info);
        if (triggered) begin
          trig_count = trig_count + 1;
        end
      end
    end
  end

  initial begin
    seed             = 32'h0141307a;
    neg_cnt          = 0;
    trig_count       = 0;
    hit_flag_negedge = 1'b0;
    tdata            = '0;
    tvalid           = 1'b0;
    threshold        = '0;
    baseline         = '0;
    m_bl             = '0;
    m_thr            = '0;
    clear_model();

    apply_reset();
    pass_through();
    threshold_crossing();
    post_window();
    length_cap();
    hit_record();
    reset_mid_window();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
+incdir+tests
src/trg_pkg.sv
src/time_base.sv
src/sample_threshold.sv
src/hit_window_ctrl.sv
src/hit_info_latch.sv
src/mm_trigger_top.sv
tests/tb_mm_trigger.sv
